// ==== hdl/rx_pkg.sv ====
// rx ring buffer shared types

package rx_pkg;

	// ----------------------------------------
	// data widths
	// ----------------------------------------

	// one word from the serial front end
	localparam int RX_WORD_W = 40;

	// one ring entry
	localparam int QWORD_W = 64;

	// one host read word of two qwords side by side
	localparam int OWORD_W = 2 * QWORD_W;

	// largest merge of residue and new word
	// 63 bits of residue plus one full word
	localparam int ACC_W = QWORD_W + RX_WORD_W - 1;

	// dropped qword counter width
	localparam int DROP_COUNT_W = 32;

	// ----------------------------------------
	// vector types
	// ----------------------------------------

	typedef logic [RX_WORD_W-1:0] rx_word_t;
	typedef logic [QWORD_W-1:0] qword_t;
	typedef logic [OWORD_W-1:0] oword_t;
	typedef logic [DROP_COUNT_W-1:0] drop_count_t;

	// packer accumulator and its bit count
	typedef logic [ACC_W-1:0] acc_t;
	// 7 bits hold 0 to 103
	typedef logic [6:0] fill_t;

	// ----------------------------------------
	// packer output beat
	// ----------------------------------------

	// valid for one cycle per finished qword
	typedef struct packed {
		logic valid;
		qword_t data;
	} qword_beat_t;

endpackage

// ==== hdl/rx_qword_packer.sv ====
// 40 to 64 bit qword gearbox

module rx_qword_packer (
	// clock
	input logic reset,
	// async reset, active high
	input logic rd_clock,
	input logic enable_sfp,
	input logic wr_valid,
	input rx_pkg::rx_word_t wr_data,
	output rx_pkg::qword_beat_t beat
);
	import rx_pkg::*;

	// ----------------------------------------
	// state
	// ----------------------------------------

	// leftover stream bits with the oldest at the lsb
	logic [QWORD_W-2:0] residue_q;
	// number of valid bits in residue_q
	fill_t fill_q;

	// output beat registers
	logic beat_valid_q;
	qword_t beat_data_q;

	// merged residue plus new word
	acc_t acc_sum;
	fill_t fill_sum;
	// merged bits after a qword leaves
	acc_t acc_shift;
	logic accept;
	logic emit;

	// words count only while the link is up
	assign accept = enable_sfp & wr_valid;

	// ----------------------------------------
	// merge
	// ----------------------------------------

	always_comb begin
		acc_sum = acc_t'(residue_q);
		fill_sum = fill_q;
		if (accept) begin
			// new word lands just above the residue
			acc_sum = acc_sum | (acc_t'(wr_data) << fill_q);
			fill_sum = fill_q + fill_t'(RX_WORD_W);
		end
	end

	// a full qword is ready
	assign emit = (fill_sum >= fill_t'(QWORD_W));
	assign acc_shift = acc_sum >> QWORD_W;

	// ----------------------------------------
	// residue and beat control
	// ----------------------------------------

	always_ff @(posedge reset or posedge rd_clock) begin
		if (rd_clock) begin
			residue_q <= '0;
			fill_q <= '0;
			beat_valid_q <= 1'b0;
		end else if (!enable_sfp) begin
			// link down drops any partial qword
			residue_q <= '0;
			fill_q <= '0;
			beat_valid_q <= 1'b0;
		end else begin
			beat_valid_q <= emit;
			if (emit) begin
				// at most 39 bits stay behind
				residue_q <= acc_shift[QWORD_W-2:0];
				fill_q <= fill_sum - fill_t'(QWORD_W);
			end else begin
				// under 64 bits the upper merge bits are zero
				residue_q <= acc_sum[QWORD_W-2:0];
				fill_q <= fill_sum;
			end
		end
	end

	// beat payload
	always_ff @(posedge reset) begin
		if (emit) begin
			beat_data_q <= acc_sum[QWORD_W-1:0];
		end
	end

	assign beat = '{valid: beat_valid_q, data: beat_data_q};

	// residue under 64 plus one word stays below 104
	assert property (@(posedge reset) disable iff (rd_clock)
		fill_sum < fill_t'(ACC_W + 1));

endmodule

// ==== hdl/rx_ring_ctl.sv ====
// rx ring pointer and status control

module rx_ring_ctl #(
	parameter int USED_QWORDS_WIDTH = 9
) (
	// clock
	input logic reset,
	// async reset, active high
	input logic rd_clock,
	input logic enable_sfp,
	// packed qwords from the gearbox
	input rx_pkg::qword_beat_t beat,
	// host read side
	input logic rd_req,
	input logic [USED_QWORDS_WIDTH-2:0] rd_address_owords,
	// memory control
	output logic wr_en,
	output logic [USED_QWORDS_WIDTH-1:0] wr_addr,
	output logic rd_en,
	output logic [USED_QWORDS_WIDTH-2:0] rd_addr,
	// status
	output logic [USED_QWORDS_WIDTH-1:0] rx_ring_wptr,
	output logic [USED_QWORDS_WIDTH:0] used_qwords,
	output rx_pkg::drop_count_t drop_count,
	output logic empty,
	output logic full
);

	// one extra bit so a full ring differs from an empty one
	localparam int PTR_W = USED_QWORDS_WIDTH + 1;
	// ring depth in qwords
	localparam logic [PTR_W-1:0] DEPTH = {1'b1, {USED_QWORDS_WIDTH{1'b0}}};
	// qwords released per host read
	localparam logic [PTR_W-1:0] OWORD_QWORDS = 2;

	// ----------------------------------------
	// pointers
	// ----------------------------------------

	logic [PTR_W-1:0] wptr_q;
	logic [PTR_W-1:0] rptr_q;
	// beat arrives with no room left
	logic drop;

	// occupancy straight from the pointer gap
	assign used_qwords = wptr_q - rptr_q;
	assign full = (used_qwords == DEPTH);
	assign empty = (used_qwords == '0);

	// low bits wrap with the ring
	assign rx_ring_wptr = wptr_q[USED_QWORDS_WIDTH-1:0];
	assign wr_addr = wptr_q[USED_QWORDS_WIDTH-1:0];

	// ----------------------------------------
	// store or drop, honour or ignore
	// ----------------------------------------

	assign wr_en = enable_sfp & beat.valid & ~full;
	assign drop = enable_sfp & beat.valid & full;

	// a read needs a whole oword buffered
	assign rd_en = enable_sfp & rd_req & (used_qwords >= OWORD_QWORDS);
	// the memory registers the oword at this address
	assign rd_addr = rd_address_owords;

	always_ff @(posedge reset or posedge rd_clock) begin
		if (rd_clock) begin
			wptr_q <= '0;
			rptr_q <= '0;
			drop_count <= '0;
		end else if (!enable_sfp) begin
			// link down empties the ring
			wptr_q <= '0;
			rptr_q <= '0;
			drop_count <= '0;
		end else begin
			if (wr_en) begin
				wptr_q <= wptr_q + 1'b1;
			end
			// honoured read frees two qwords
			if (rd_en) begin
				rptr_q <= rptr_q + OWORD_QWORDS;
			end
			if (drop) begin
				drop_count <= drop_count + 1'b1;
			end
		end
	end

	// ----------------------------------------
	// checks
	// ----------------------------------------

	// a full ring takes no write and never grows
	assert property (@(posedge reset) disable iff (rd_clock)
		$past(full && enable_sfp) |-> used_qwords <= $past(used_qwords));

	// pointer gap stays within the ring
	assert property (@(posedge reset) disable iff (rd_clock)
		used_qwords <= DEPTH);

	// a short ring ignores the read and keeps its qwords
	assert property (@(posedge reset) disable iff (rd_clock)
		$past(enable_sfp && rd_req && used_qwords < OWORD_QWORDS)
		|-> used_qwords >= $past(used_qwords));

endmodule

// ==== hdl/rx_ring_ram.sv ====
// rx ring qword memory

module rx_ring_ram #(
	parameter int USED_QWORDS_WIDTH = 9
) (
	// clock
	input logic reset,
	// async reset, active high
	input logic rd_clock,
	// write data comes straight from the gearbox
	input rx_pkg::qword_beat_t beat,
	input logic wr_en,
	input logic [USED_QWORDS_WIDTH-1:0] wr_addr,
	// oword read port
	input logic rd_en,
	input logic [USED_QWORDS_WIDTH-2:0] rd_addr,
	output rx_pkg::oword_t rd_data,
	output logic rd_data_valid
);
	import rx_pkg::*;

	// ring depth in qwords
	localparam int DEPTH = 1 << USED_QWORDS_WIDTH;

	qword_t mem [DEPTH];

	// qword pair behind one oword
	logic [USED_QWORDS_WIDTH-1:0] lo_addr;
	logic [USED_QWORDS_WIDTH-1:0] hi_addr;

	assign lo_addr = {rd_addr, 1'b0};
	assign hi_addr = {rd_addr, 1'b1};

	// ----------------------------------------
	// write port
	// ----------------------------------------

	always_ff @(posedge reset) begin
		if (wr_en) begin
			mem[wr_addr] <= beat.data;
		end
	end

	// ----------------------------------------
	// read port
	// ----------------------------------------

	// even qword low, odd qword high
	always_ff @(posedge reset) begin
		if (rd_en) begin
			rd_data <= {mem[hi_addr], mem[lo_addr]};
		end
	end

	// valid follows the data by the same edge
	always_ff @(posedge reset or posedge rd_clock) begin
		if (rd_clock) begin
			rd_data_valid <= 1'b0;
		end else begin
			rd_data_valid <= rd_en;
		end
	end

	// the controller only writes on a packer beat
	assert property (@(posedge reset) disable iff (rd_clock)
		wr_en |-> beat.valid);

endmodule

// ==== hdl/sonic_rx_ctl.sv ====
// rx ring buffer top level

module sonic_rx_ctl #(
	// log2 of ring depth in qwords
	parameter int USED_QWORDS_WIDTH = 9
) (
	// clock
	input logic reset,
	// async reset, active high
	input logic rd_clock,
	// link enable level
	input logic enable_sfp,
	// serial front end words
	input logic wr_valid,
	input rx_pkg::rx_word_t wr_data,
	// host reads
	input logic rd_req,
	input logic [USED_QWORDS_WIDTH-2:0] rd_address_owords,
	output rx_pkg::oword_t rd_data,
	output logic rd_data_valid,
	// ring status
	output logic [USED_QWORDS_WIDTH-1:0] rx_ring_wptr,
	output logic [USED_QWORDS_WIDTH:0] used_qwords,
	output rx_pkg::drop_count_t drop_count,
	output logic empty,
	output logic full
);
	import rx_pkg::*;

	// ----------------------------------------
	// internal nets
	// ----------------------------------------

	// finished qwords to controller and memory
	qword_beat_t beat;

	// controller to memory
	logic wr_en;
	logic [USED_QWORDS_WIDTH-1:0] wr_addr;
	logic rd_en;
	logic [USED_QWORDS_WIDTH-2:0] rd_addr;

	// word to qword gearbox
	rx_qword_packer packer_inst (
		.reset (reset),
		.rd_clock (rd_clock),
		.enable_sfp (enable_sfp),
		.wr_valid (wr_valid),
		.wr_data (wr_data),
		.beat (beat)
	);

	// pointers, occupancy and drops
	rx_ring_ctl #(
		.USED_QWORDS_WIDTH (USED_QWORDS_WIDTH)
	) ctl_inst (
		.reset (reset),
		.rd_clock (rd_clock),
		.enable_sfp (enable_sfp),
		.beat (beat),
		.rd_req (rd_req),
		.rd_address_owords (rd_address_owords),
		.wr_en (wr_en),
		.wr_addr (wr_addr),
		.rd_en (rd_en),
		.rd_addr (rd_addr),
		.rx_ring_wptr (rx_ring_wptr),
		.used_qwords (used_qwords),
		.drop_count (drop_count),
		.empty (empty),
		.full (full)
	);

	// qword store, oword reads
	rx_ring_ram #(
		.USED_QWORDS_WIDTH (USED_QWORDS_WIDTH)
	) ram_inst (
		.reset (reset),
		.rd_clock (rd_clock),
		.beat (beat),
		.wr_en (wr_en),
		.wr_addr (wr_addr),
		.rd_en (rd_en),
		.rd_addr (rd_addr),
		.rd_data (rd_data),
		.rd_data_valid (rd_data_valid)
	);

endmodule

// ==== dv/sonic_rx_ctl_tb.sv ====
// rx ring buffer testbench

module sonic_rx_ctl_tb;
	import rx_pkg::*;

	localparam int QW = 6;
	localparam int DEPTH = 1 << QW;
	localparam int PERIOD = 100;
	localparam int RESET_CYCLES = 16;
	// per test cycle budget for reset, packing, release, overflow, wraparound and disable
	localparam int RUN_CYCLES = RESET_CYCLES + 20 + 20 + 200 + 560 + 30;

	typedef logic [QW-2:0] oword_addr_t;

	// DUT inputs idle at time zero
	logic reset = 1'b0;
	logic rd_clock = 1'b1;
	logic enable_sfp = 1'b1;
	logic wr_valid = 1'b0;
	rx_word_t wr_data = '0;
	logic rd_req = 1'b0;
	oword_addr_t rd_address_owords = '0;
	// DUT outputs
	oword_t rd_data;
	logic rd_data_valid;
	logic [QW-1:0] rx_ring_wptr;
	logic [QW:0] used_qwords;
	drop_count_t drop_count;
	logic empty;
	logic full;

	// ----------------------------------------
	// reference model state
	// ----------------------------------------

	logic [31:0] lfsr = 32'h2aaa8d8d;
	// accepted stream bits not yet in a qword, oldest first
	bit stream_bits[$];
	qword_t model_mem [DEPTH];
	int model_used = 0;
	int model_wptr = 0;
	int model_rptr = 0;
	int model_drops = 0;
	// owords owed by honoured reads
	oword_t expected_q[$];
	oword_t want;

	string test_name = "none";
	int errors = 0;
	int checks = 0;
	int num_tests = 0;
	int failed_tests = 0;
	int test_start_errors = 0;

	sonic_rx_ctl #(
		.USED_QWORDS_WIDTH (QW)
	) sonic_rx_ctl_inst (
		.reset (reset),
		.rd_clock (rd_clock),
		.enable_sfp (enable_sfp),
		.wr_valid (wr_valid),
		.wr_data (wr_data),
		.rd_req (rd_req),
		.rd_address_owords (rd_address_owords),
		.rd_data (rd_data),
		.rd_data_valid (rd_data_valid),
		.rx_ring_wptr (rx_ring_wptr),
		.used_qwords (used_qwords),
		.drop_count (drop_count),
		.empty (empty),
		.full (full)
	);

	always #(PERIOD / 2) reset = ~reset;

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	// one lfsr step per word bit
	task automatic random_word(output rx_word_t w);
		for (int b = 0; b < RX_WORD_W; b++) begin
			lfsr = lfsr_step(lfsr);
			w[b] = lfsr[0];
		end
	endtask

	// append word to the stream, cut qwords, store or drop
	task automatic model_accept(input rx_word_t w);
		qword_t q;
		for (int b = 0; b < RX_WORD_W; b++) begin
			stream_bits.push_back(w[b]);
		end
		while (stream_bits.size() >= QWORD_W) begin
			for (int b = 0; b < QWORD_W; b++) begin
				q[b] = stream_bits.pop_front();
			end
			if (model_used < DEPTH) begin
				model_mem[model_wptr % DEPTH] = q;
				model_wptr++;
				model_used++;
			end else begin
				model_drops++;
			end
		end
	endtask

	// link down clears residue and counters
	task automatic model_clear();
		stream_bits.delete();
		model_used = 0;
		model_wptr = 0;
		model_rptr = 0;
		model_drops = 0;
	endtask

	// even qword low, odd qword high
	function automatic oword_t expected_oword(input int addr);
		return {model_mem[2 * addr + 1], model_mem[2 * addr]};
	endfunction

	task automatic check_value(input string what, input longint expected, input longint actual);
		checks++;
		if (expected != actual) begin
			$display("FAIL %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
			errors++;
		end
	endtask

	task automatic check_status();
		check_value("used_qwords", model_used, used_qwords);
		check_value("rx_ring_wptr", model_wptr % DEPTH, rx_ring_wptr);
		check_value("drop_count", model_drops, drop_count);
		check_value("empty", model_used == 0, empty);
		check_value("full", model_used == DEPTH, full);
	endtask

	// ----------------------------------------
	// stimulus tasks on falling edges
	// ----------------------------------------

	task automatic send_words(input int n);
		rx_word_t w;
		for (int i = 0; i < n; i++) begin
			@(negedge reset);
			random_word(w);
			wr_valid = 1'b1;
			wr_data = w;
			model_accept(w);
		end
		// pointers move two cycles after the last word
		@(negedge reset);
		wr_valid = 1'b0;
		@(negedge reset);
	endtask

	// read the oldest oword in the ring
	task automatic read_oldest();
		@(negedge reset);
		rd_req = 1'b1;
		rd_address_owords = oword_addr_t'((model_rptr / 2) % (DEPTH / 2));
		if (model_used >= 2) begin
			expected_q.push_back(expected_oword((model_rptr / 2) % (DEPTH / 2)));
			model_used -= 2;
			model_rptr += 2;
		end
		@(negedge reset);
		rd_req = 1'b0;
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_start_errors = errors;
		num_tests++;
	endtask

	task automatic end_test();
		// let the last read data reach the compare
		@(negedge reset);
		if (errors == test_start_errors) begin
			$display("test %s: ok", test_name);
		end else begin
			$display("test %s: %0d errors", test_name, errors - test_start_errors);
			failed_tests++;
		end
	endtask

	// read data compare at mid-cycle
	always @(negedge reset) begin
		if (!rd_clock && rd_data_valid) begin
			if (expected_q.size() == 0) begin
				$display("FAIL %s: rd_data_valid rose with no honoured read pending", test_name);
				errors++;
			end else begin
				want = expected_q.pop_front();
				checks++;
				if (rd_data !== want) begin
					$display("FAIL %s rd_data: expected %h, actual %h", test_name, want, rd_data);
					errors++;
				end
			end
		end
	end

	initial begin
		#(2 * RUN_CYCLES * PERIOD);
		$display("watchdog: tests still running after %0d cycles", 2 * RUN_CYCLES);
		$display("Result: FAILED");
		$finish;
	end

	initial begin : main
		int used_before;
		rx_word_t w;

		repeat (RESET_CYCLES) @(negedge reset);
		rd_clock = 1'b0;

		start_test("reset");
		check_status();
		end_test();

		start_test("packing");
		send_words(8);
		check_value("used_qwords", 5, used_qwords);
		check_status();
		read_oldest();
		read_oldest();
		end_test();

		// 2 more qwords so one read leaves a single qword
		start_test("release");
		send_words(4);
		used_before = model_used;
		read_oldest();
		check_value("used_qwords", used_before - 2, used_qwords);
		check_status();
		read_oldest();
		check_value("rd_data_valid", 0, rd_data_valid);
		check_status();
		end_test();

		// 128 words make 80 qwords for a ring of 64
		start_test("overflow");
		send_words(128);
		check_value("used_qwords", DEPTH, used_qwords);
		check_status();
		repeat (DEPTH / 2) read_oldest();
		check_status();
		end_test();

		// net gain of one qword per round and 200 qwords in total
		start_test("wraparound");
		for (int r = 0; r < 40; r++) begin
			send_words(8);
			check_status();
			for (int k = 0; k < 2 && model_used >= 2; k++) begin
				read_oldest();
			end
		end
		end_test();

		start_test("disable");
		send_words(3);
		@(negedge reset);
		enable_sfp = 1'b0;
		model_clear();
		// words while the link is down go nowhere
		repeat (2) begin
			@(negedge reset);
			random_word(w);
			wr_valid = 1'b1;
			wr_data = w;
		end
		@(negedge reset);
		wr_valid = 1'b0;
		check_status();
		enable_sfp = 1'b1;
		send_words(8);
		check_status();
		read_oldest();
		read_oldest();
		end_test();

		if (expected_q.size() != 0) begin
			$display("%0d honoured reads never returned data", expected_q.size());
			errors++;
		end
		$display("tests: %0d, failed: %0d, checks: %0d, errors: %0d",
			num_tests, failed_tests, checks, errors);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

// ==== project.f ====
hdl/rx_pkg.sv
hdl/rx_qword_packer.sv
hdl/rx_ring_ctl.sv
hdl/rx_ring_ram.sv
hdl/sonic_rx_ctl.sv
dv/sonic_rx_ctl_tb.sv

// ==== Makefile ====
TOP := sonic_rx_ctl_tb
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f project.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Result: FAILED" $(LOG) || ! grep -q "Result: PASSED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	verilator --lint-only -Wall --timing -f project.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)
